//--- rtl/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // one SCL period is four quarters
    localparam logic [3:0] QUARTER_CLKS = 4'd2;
    localparam logic [3:0] DEV_TYPE     = 4'b1010;  // 24Cxx device code

    localparam logic [3:0] REG_ADDR   = 4'h0;
    localparam logic [3:0] REG_WDATA  = 4'h4;
    localparam logic [3:0] REG_CMD    = 4'h8;
    localparam logic [3:0] REG_STATUS = 4'hC;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_WRITE,
        OP_READ
    } eeprom_op_e;

    typedef struct packed {
        eeprom_op_e  op;
        logic [10:0] addr;
        logic [7:0]  wdata;
    } eeprom_cmd_t;

    typedef struct packed {
        logic       done;
        logic       nack;
        logic [7:0] rdata;
    } eeprom_rsp_t;

    typedef struct packed {
        logic scl;      // 1 = released
        logic sda_low;  // 1 = pulled down
    } i2c_line_t;

    typedef struct packed {
        logic [3:0] dev;
        logic [2:0] block;  // address bits 10:8
        logic       rw;
    } ctrl_byte_t;

    typedef union packed {
        logic [7:0] raw;
        ctrl_byte_t ctrl;
    } i2c_byte_u;

endpackage

`default_nettype wire

//--- rtl/eeprom_apb_regs.sv
`default_nettype none
`timescale 1ns/1ns

module eeprom_apb_regs (
    input  wire                     CLK,
    input  wire                     RESET,
    input  wire                     psel,
    input  wire                     penable,
    input  wire                     pwrite,
    input  wire [3:0]               paddr,
    input  wire [31:0]              pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    output eeprom_pkg::eeprom_cmd_t cmd,
    input  wire                     busy,
    input  wire eeprom_pkg::eeprom_rsp_t rsp
);

    logic                   access;
    logic                   mapped;
    logic                   accept;
    logic [10:0]            addr_q;
    logic [7:0]             wdata_q;
    eeprom_pkg::eeprom_op_e op_q;
    logic                   stat_busy;
    logic                   stat_done;
    logic                   stat_nack;
    logic [7:0]             stat_rdata;

    assign access = psel && penable;
    assign mapped = (paddr == eeprom_pkg::REG_ADDR) || (paddr == eeprom_pkg::REG_WDATA) ||
                    (paddr == eeprom_pkg::REG_CMD) || (paddr == eeprom_pkg::REG_STATUS);

    // stat_busy covers the gap before the sequencer raises busy
    assign accept = access && pwrite && (paddr == eeprom_pkg::REG_CMD) &&
                    (pwdata[0] || pwdata[1]) && !busy && !stat_busy;

    assign pready  = 1'b1;
    assign pslverr = access && !mapped;

    assign cmd = '{op: op_q, addr: addr_q, wdata: wdata_q};

    always_comb
    begin
        prdata = 32'd0;
        case (paddr)
            eeprom_pkg::REG_ADDR:   prdata = {21'd0, addr_q};
            eeprom_pkg::REG_WDATA:  prdata = {24'd0, wdata_q};
            eeprom_pkg::REG_STATUS: prdata = {16'd0, stat_rdata, 5'd0,
                                              stat_nack, stat_done, stat_busy};
            default:                prdata = 32'd0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            addr_q     <= 11'd0;
            wdata_q    <= 8'd0;
            op_q       <= eeprom_pkg::OP_NONE;
            stat_busy  <= 1'b0;
            stat_done  <= 1'b0;
            stat_nack  <= 1'b0;
            stat_rdata <= 8'd0;
        end
        else
        begin
            op_q <= eeprom_pkg::OP_NONE;  // one-cycle command
            if (access && pwrite && (paddr == eeprom_pkg::REG_ADDR))
                addr_q <= pwdata[10:0];
            if (access && pwrite && (paddr == eeprom_pkg::REG_WDATA))
                wdata_q <= pwdata[7:0];
            if (accept)
            begin
                op_q      <= pwdata[0] ? eeprom_pkg::OP_WRITE : eeprom_pkg::OP_READ;
                stat_busy <= 1'b1;
                stat_done <= 1'b0;
                stat_nack <= 1'b0;
            end
            else if (rsp.done)
            begin
                stat_busy  <= 1'b0;
                stat_done  <= 1'b1;
                stat_nack  <= rsp.nack;
                stat_rdata <= rsp.rdata;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/i2c_cond_gen.sv
`default_nettype none
`timescale 1ns/1ns

module i2c_cond_gen (
    input  wire                   CLK,
    input  wire                   RESET,
    input  wire                   cond_req,
    input  wire                   cond_is_stop,
    output logic                  cond_done,
    output eeprom_pkg::i2c_line_t line
);

    logic       active;
    logic       stop_q;
    logic [1:0] q;      // quarter of the bit
    logic [3:0] cnt;
    logic       tick;

    assign tick      = (cnt == eeprom_pkg::QUARTER_CLKS - 4'd1);
    assign cond_done = active && tick && (q == 2'd3);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active <= 1'b0;
            stop_q <= 1'b0;
            q      <= 2'd0;
            cnt    <= 4'd0;
        end
        else if (!active)
        begin
            q   <= 2'd0;
            cnt <= 4'd0;
            if (cond_req)
            begin
                active <= 1'b1;
                stop_q <= cond_is_stop;
            end
        end
        else if (tick)
        begin
            cnt <= 4'd0;
            q   <= q + 2'd1;
            if (q == 2'd3)
                active <= 1'b0;
        end
        else
            cnt <= cnt + 4'd1;
    end

    always_comb
    begin
        line.scl     = 1'b1;
        line.sda_low = 1'b0;
        if (active && !stop_q)
        begin
            // start: SDA falls in q2 with SCL high, SCL drops in q3
            line.scl     = (q == 2'd1) || (q == 2'd2);
            line.sda_low = q[1];
        end
        else if (active)
        begin
            line.scl     = (q != 2'd0);
            line.sda_low = (q < 2'd2);  // released in q2, SCL high
        end
    end

endmodule

`default_nettype wire

//--- rtl/i2c_byte_shift.sv
`default_nettype none
`timescale 1ns/1ns

module i2c_byte_shift (
    input  wire                   CLK,
    input  wire                   RESET,
    input  wire                   shift_req,
    input  wire                   rx_mode,
    input  wire                   master_nack,
    input  wire eeprom_pkg::i2c_byte_u tx_byte,
    input  wire                   sda_in,
    output logic                  shift_done,
    output logic [7:0]            rx_byte,
    output logic                  ack_seen,
    output eeprom_pkg::i2c_line_t line
);

    logic                  active;
    logic                  rx_q;
    logic                  mnack_q;
    logic [1:0]            q;
    logic [3:0]            cnt;
    logic [3:0]            bit_cnt;  // 0..7 data, 8 ack
    logic                  tick;
    logic                  last_bit;
    logic                  sample;
    eeprom_pkg::i2c_byte_u tx_q;

    assign tick       = (cnt == eeprom_pkg::QUARTER_CLKS - 4'd1);
    assign last_bit   = (bit_cnt == 4'd8);
    assign sample     = active && tick && (q == 2'd1);  // middle of SCL high
    assign shift_done = active && tick && (q == 2'd3) && last_bit;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            rx_q    <= 1'b0;
            mnack_q <= 1'b0;
            q       <= 2'd0;
            cnt     <= 4'd0;
            bit_cnt <= 4'd0;
        end
        else if (!active)
        begin
            q       <= 2'd0;
            cnt     <= 4'd0;
            bit_cnt <= 4'd0;
            if (shift_req)
            begin
                active  <= 1'b1;
                rx_q    <= rx_mode;
                mnack_q <= master_nack;
            end
        end
        else if (tick)
        begin
            cnt <= 4'd0;
            q   <= q + 2'd1;
            if (q == 2'd3)
            begin
                bit_cnt <= bit_cnt + 4'd1;
                if (last_bit)
                    active <= 1'b0;
            end
        end
        else
            cnt <= cnt + 4'd1;
    end

    always_ff @(posedge CLK)
    begin
        if (!active && shift_req)
            tx_q <= tx_byte;
        if (sample && last_bit)
            ack_seen <= !sda_in;
        else if (sample)
            rx_byte <= {rx_byte[6:0], sda_in};  // msb first
    end

    always_comb
    begin
        line.scl     = 1'b1;
        line.sda_low = 1'b0;
        if (active)
        begin
            line.scl = (q == 2'd1) || (q == 2'd2);
            if (last_bit)
                line.sda_low = rx_q && !mnack_q;  // our ack on reads
            else if (!rx_q)
                line.sda_low = !tx_q.raw[3'd7 - bit_cnt[2:0]];
        end
    end

endmodule

`default_nettype wire

//--- rtl/eeprom_seq.sv
`default_nettype none
`timescale 1ns/1ns

module eeprom_seq (
    input  wire                        CLK,
    input  wire                        RESET,
    input  wire eeprom_pkg::eeprom_cmd_t cmd,
    output logic                       busy,
    output eeprom_pkg::eeprom_rsp_t    rsp,
    output logic                       cond_req,
    output logic                       cond_is_stop,
    input  wire                        cond_done,
    input  wire eeprom_pkg::i2c_line_t cond_line,
    output logic                       shift_req,
    output logic                       rx_mode,
    output logic                       master_nack,
    output eeprom_pkg::i2c_byte_u      tx_byte,
    input  wire                        shift_done,
    input  wire [7:0]                  rx_byte,
    input  wire                        ack_seen,
    input  wire eeprom_pkg::i2c_line_t shift_line,
    output eeprom_pkg::i2c_line_t      line
);

    typedef enum logic [8:0] {
        PH_IDLE   = 9'b0_0000_0001,
        PH_START  = 9'b0_0000_0010,
        PH_CTRL_W = 9'b0_0000_0100,
        PH_ADDR   = 9'b0_0000_1000,
        PH_DATA   = 9'b0_0001_0000,
        PH_RSTART = 9'b0_0010_0000,
        PH_CTRL_R = 9'b0_0100_0000,
        PH_READ   = 9'b0_1000_0000,
        PH_STOP   = 9'b1_0000_0000
    } phase_e;

    phase_e                 phase;
    eeprom_pkg::eeprom_op_e op_q;
    logic [10:0]            addr_q;
    logic [7:0]             wdata_q;
    logic [7:0]             rdata_q;
    logic                   done_q;
    logic                   nack_q;
    logic                   cond_act;
    logic                   shift_act;
    eeprom_pkg::i2c_line_t  held_line;

    assign rsp = '{done: done_q, nack: nack_q, rdata: rdata_q};

    // between phases the bus keeps its last state
    assign line = cond_act ? cond_line : (shift_act ? shift_line : held_line);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase        <= PH_IDLE;
            busy         <= 1'b0;
            done_q       <= 1'b0;
            nack_q       <= 1'b0;
            rdata_q      <= 8'd0;
            cond_req     <= 1'b0;
            cond_is_stop <= 1'b0;
            shift_req    <= 1'b0;
            rx_mode      <= 1'b0;
            master_nack  <= 1'b0;
            cond_act     <= 1'b0;
            shift_act    <= 1'b0;
            held_line    <= '{scl: 1'b1, sda_low: 1'b0};
        end
        else
        begin
            cond_req  <= 1'b0;
            shift_req <= 1'b0;
            done_q    <= 1'b0;
            held_line <= line;
            if (cond_req)
                cond_act <= 1'b1;
            else if (cond_done)
                cond_act <= 1'b0;
            if (shift_req)
                shift_act <= 1'b1;
            else if (shift_done)
                shift_act <= 1'b0;

            case (phase)
                PH_IDLE:
                    if (cmd.op != eeprom_pkg::OP_NONE)
                    begin
                        busy         <= 1'b1;
                        nack_q       <= 1'b0;
                        cond_req     <= 1'b1;
                        cond_is_stop <= 1'b0;
                        phase        <= PH_START;
                    end
                PH_START, PH_RSTART:
                    if (cond_done)
                    begin
                        shift_req   <= 1'b1;
                        rx_mode     <= 1'b0;
                        master_nack <= 1'b0;
                        phase       <= (phase == PH_START) ? PH_CTRL_W : PH_CTRL_R;
                    end
                PH_CTRL_W, PH_ADDR, PH_CTRL_R:
                    if (shift_done && !ack_seen)
                    begin
                        nack_q       <= 1'b1;  // abort
                        cond_req     <= 1'b1;
                        cond_is_stop <= 1'b1;
                        phase        <= PH_STOP;
                    end
                    else if (shift_done && phase == PH_CTRL_W)
                    begin
                        shift_req <= 1'b1;
                        phase     <= PH_ADDR;
                    end
                    else if (shift_done && phase == PH_CTRL_R)
                    begin
                        shift_req   <= 1'b1;
                        rx_mode     <= 1'b1;
                        master_nack <= 1'b1;  // single byte read
                        phase       <= PH_READ;
                    end
                    else if (shift_done && op_q == eeprom_pkg::OP_WRITE)
                    begin
                        shift_req <= 1'b1;
                        phase     <= PH_DATA;
                    end
                    else if (shift_done)
                    begin
                        cond_req     <= 1'b1;
                        cond_is_stop <= 1'b0;
                        phase        <= PH_RSTART;
                    end
                PH_DATA, PH_READ:
                    if (shift_done)
                    begin
                        if (phase == PH_DATA)
                            nack_q <= !ack_seen;
                        else
                            rdata_q <= rx_byte;
                        cond_req     <= 1'b1;
                        cond_is_stop <= 1'b1;
                        phase        <= PH_STOP;
                    end
                PH_STOP:
                    if (cond_done)
                    begin
                        done_q <= 1'b1;
                        busy   <= 1'b0;
                        phase  <= PH_IDLE;
                    end
                default:
                    phase <= PH_IDLE;
            endcase
        end
    end

    // transaction payload
    always_ff @(posedge CLK)
    begin
        if (phase == PH_IDLE && cmd.op != eeprom_pkg::OP_NONE)
        begin
            op_q    <= cmd.op;
            addr_q  <= cmd.addr;
            wdata_q <= cmd.wdata;
        end
        if ((phase == PH_START || phase == PH_RSTART) && cond_done)
        begin
            tx_byte.ctrl.dev   <= eeprom_pkg::DEV_TYPE;
            tx_byte.ctrl.block <= addr_q[10:8];
            tx_byte.ctrl.rw    <= (phase == PH_RSTART);  // read after restart
        end
        else if (phase == PH_CTRL_W && shift_done)
            tx_byte.raw <= addr_q[7:0];
        else if (phase == PH_ADDR && shift_done)
            tx_byte.raw <= wdata_q;
    end

endmodule

`default_nettype wire

//--- rtl/eeprom_ctl_top.sv
`default_nettype none
`timescale 1ns/1ns

module eeprom_ctl_top (
    input  wire         CLK,
    input  wire         RESET,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire [3:0]   paddr,
    input  wire [31:0]  pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        scl,
    output logic        sda_low,
    input  wire         sda_in
);

    eeprom_pkg::eeprom_cmd_t cmd;
    eeprom_pkg::eeprom_rsp_t rsp;
    eeprom_pkg::i2c_line_t   cond_line;
    eeprom_pkg::i2c_line_t   shift_line;
    eeprom_pkg::i2c_line_t   line;
    eeprom_pkg::i2c_byte_u   tx_byte;
    logic                    busy;
    logic                    cond_req;
    logic                    cond_is_stop;
    logic                    cond_done;
    logic                    shift_req;
    logic                    rx_mode;
    logic                    master_nack;
    logic                    shift_done;
    logic [7:0]              rx_byte;
    logic                    ack_seen;

    assign scl     = line.scl;
    assign sda_low = line.sda_low;

    eeprom_apb_regs regs_inst (.*);

    eeprom_seq seq_inst (.*);

    i2c_cond_gen cond_inst (
        .CLK, .RESET, .cond_req, .cond_is_stop, .cond_done, .line(cond_line)
    );

    i2c_byte_shift shift_inst (
        .CLK, .RESET, .shift_req, .rx_mode, .master_nack, .tx_byte, .sda_in,
        .shift_done, .rx_byte, .ack_seen, .line(shift_line)
    );

endmodule

`default_nettype wire

//--- dv/eeprom_model.sv
`default_nettype none
`timescale 1ns/1ns

module eeprom_model (
    input  wire  CLK,
    input  wire  RESET,
    input  wire  scl,
    input  wire  sda,         // resolved bus level
    input  wire  ack_off,     // suppress every acknowledge
    output logic sda_pull,
    output logic frame_open,  // between START and STOP
    output int   stop_cnt,
    output int   write_cnt
);

    typedef enum logic [2:0] {S_IDLE, S_RX, S_ACK, S_TX, S_TX_ACK} state_e;

    logic [7:0]            mem [0:2047];
    state_e                state;
    logic                  scl_d;
    logic                  sda_d;
    logic [7:0]            sh;
    logic [3:0]            bit_cnt;
    logic [1:0]            byte_idx;
    logic                  rw_q;
    logic [2:0]            block_q;
    logic [10:0]           ptr;
    logic                  pend_wr;
    logic [7:0]            pend_data;
    logic                  start_cond;
    logic                  stop_cond;
    logic                  scl_rise;
    logic                  scl_fall;
    eeprom_pkg::i2c_byte_u rx_u;

    assign start_cond = scl && scl_d && sda_d && !sda;
    assign stop_cond  = scl && scl_d && !sda_d && sda;
    assign scl_rise   = scl && !scl_d;
    assign scl_fall   = !scl && scl_d;
    assign rx_u.raw   = sh;

    initial
    begin
        logic [10:0] a;
        for (int i = 0; i < 2048; i++)
        begin
            a = i[10:0];
            mem[a] = a[7:0] ^ {a[10:8], 5'b10110};  // block bits folded in
        end
    end

    always @(posedge CLK)
    begin
        scl_d <= scl;
        sda_d <= sda;
        if (RESET)
        begin
            state      <= S_IDLE;
            sda_pull   <= 1'b0;
            frame_open <= 1'b0;
            stop_cnt   <= 0;
            write_cnt  <= 0;
            pend_wr    <= 1'b0;
            ptr        <= 11'd0;
            bit_cnt    <= 4'd0;
            byte_idx   <= 2'd0;
            rw_q       <= 1'b0;
        end
        else if (start_cond)
        begin
            state      <= S_RX;
            bit_cnt    <= 4'd0;
            byte_idx   <= 2'd0;
            sda_pull   <= 1'b0;
            frame_open <= 1'b1;
            pend_wr    <= 1'b0;
        end
        else if (stop_cond)
        begin
            if (pend_wr)
            begin
                mem[ptr]  <= pend_data;  // write cycle starts at STOP
                write_cnt <= write_cnt + 1;
            end
            pend_wr    <= 1'b0;
            state      <= S_IDLE;
            sda_pull   <= 1'b0;
            frame_open <= 1'b0;
            stop_cnt   <= stop_cnt + 1;
        end
        else
        begin
            case (state)
                S_RX:
                    if (scl_rise && bit_cnt < 4'd8)
                    begin
                        sh      <= {sh[6:0], sda};
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                    else if (scl_fall && bit_cnt == 4'd8)
                    begin
                        bit_cnt <= 4'd0;
                        if (byte_idx == 2'd0 && rx_u.ctrl.dev != eeprom_pkg::DEV_TYPE)
                            state <= S_IDLE;  // not addressed, wait for STOP
                        else
                        begin
                            sda_pull <= !ack_off;  // bytes still taken without ack
                            state    <= S_ACK;
                            byte_idx <= byte_idx + 2'd1;
                            if (byte_idx == 2'd0)
                            begin
                                block_q <= rx_u.ctrl.block;
                                rw_q    <= rx_u.ctrl.rw;
                            end
                            else if (byte_idx == 2'd1)
                                ptr <= {block_q, sh};
                            else
                            begin
                                pend_wr   <= 1'b1;
                                pend_data <= sh;
                            end
                        end
                    end
                S_ACK:
                    if (scl_fall && rw_q)
                    begin
                        sda_pull <= !mem[ptr][7];
                        sh       <= {mem[ptr][6:0], 1'b0};
                        bit_cnt  <= 4'd1;
                        state    <= S_TX;
                    end
                    else if (scl_fall)
                    begin
                        sda_pull <= 1'b0;
                        state    <= S_RX;
                    end
                S_TX:
                    if (scl_fall && bit_cnt < 4'd8)
                    begin
                        sda_pull <= !sh[7];
                        sh       <= {sh[6:0], 1'b0};
                        bit_cnt  <= bit_cnt + 4'd1;
                    end
                    else if (scl_fall)
                    begin
                        sda_pull <= 1'b0;  // master answers
                        state    <= S_TX_ACK;
                    end
                S_TX_ACK:
                    if (scl_rise)
                    begin
                        ptr   <= ptr + 11'd1;
                        state <= S_IDLE;  // sequential reads not modeled
                    end
                default:
                    ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_eeprom_ctl.sv
`default_nettype none
`timescale 1ns/1ns

module tb_eeprom_ctl;

    // a read is under 400 cycles; 50 slots cover about 34 transfers plus polling
    localparam int TX_BUDGET      = 400;
    localparam int TIMEOUT_CYCLES = 50 * TX_BUDGET;

    logic        CLK = 1'b0;
    logic        RESET;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        scl;
    logic        sda_low;
    logic        sda_bus;
    logic        model_pull;
    logic        ack_off;
    logic        frame_open;
    int          stop_cnt;
    int          write_cnt;
    int          mismatch_cnt;
    int          fail_cnt;
    int          cycle_cnt;
    logic [31:0] rng;
    logic [7:0]  last_rdata;
    logic [7:0]  exp_mem [0:2047];

    assign sda_bus = !(sda_low || model_pull);  // wired-AND with pull-up

    eeprom_ctl_top eeprom_ctl_top_inst (
        .CLK     (CLK),
        .RESET   (RESET),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda_bus)
    );

    eeprom_model model_inst (
        .CLK        (CLK),
        .RESET      (RESET),
        .scl        (scl),
        .sda        (sda_bus),
        .ack_off    (ack_off),
        .sda_pull   (model_pull),
        .frame_open (frame_open),
        .stop_cnt   (stop_cnt),
        .write_cnt  (write_cnt)
    );

    initial
    begin
        forever #2 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic eeprom_pkg::eeprom_rsp_t status_to_rsp(input logic [31:0] status);
        eeprom_pkg::eeprom_rsp_t r;
        r.done  = status[1];
        r.nack  = status[2];
        r.rdata = status[15:8];
        return r;
    endfunction

    task automatic report_failure(input string what);
        fail_cnt++;
        $display("error: %s", what);
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
        begin
            mismatch_cnt++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            mismatch_cnt++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_rsp(input string name, input eeprom_pkg::eeprom_rsp_t got,
                             input eeprom_pkg::eeprom_rsp_t exp);
        if (got !== exp)
        begin
            mismatch_cnt++;
            $display("mismatch %s: got done %h nack %h rdata %h", name,
                     got.done, got.nack, got.rdata);
            $display("    expected done %h nack %h rdata %h",
                     exp.done, exp.nack, exp.rdata);
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        @(negedge CLK);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge CLK);
        penable = 1'b1;
        @(negedge CLK);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge CLK);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge CLK);
        penable = 1'b1;
        @(negedge CLK);
        data    = prdata;  // still in the access phase
        err     = pslverr;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_done(output logic [31:0] status);
        logic err;
        status = 32'h1;
        while (status[0])
            apb_read(eeprom_pkg::REG_STATUS, status, err);
    endtask

    task automatic ends_with_stop(input string name);
        if (frame_open)
            report_failure({name, ": bus did not end with a STOP"});
    endtask

    task automatic transfer(input logic [10:0] addr, input logic [7:0] wdata,
                            input logic [1:0] cmd_bits, input eeprom_pkg::eeprom_rsp_t exp,
                            input string name);
        logic [31:0] status;
        apb_write(eeprom_pkg::REG_ADDR, {21'd0, addr});
        apb_write(eeprom_pkg::REG_WDATA, {24'd0, wdata});
        apb_write(eeprom_pkg::REG_CMD, {30'd0, cmd_bits});
        wait_done(status);
        check_rsp(name, status_to_rsp(status), exp);
        ends_with_stop(name);
    endtask

    task automatic write_byte(input logic [10:0] addr, input logic [7:0] data);
        eeprom_pkg::eeprom_rsp_t exp;
        exp.done  = 1'b1;
        exp.nack  = 1'b0;
        exp.rdata = last_rdata;  // rdata untouched by writes
        transfer(addr, data, 2'b01, exp, $sformatf("write %h", addr));
        exp_mem[addr] = data;
    endtask

    task automatic read_byte(input logic [10:0] addr);
        eeprom_pkg::eeprom_rsp_t exp;
        exp.done  = 1'b1;
        exp.nack  = 1'b0;
        exp.rdata = exp_mem[addr];
        transfer(addr, 8'h00, 2'b10, exp, $sformatf("read %h", addr));
        last_rdata = exp_mem[addr];
    endtask

    task automatic reset_and_regs();
        logic [31:0] data;
        logic        err;
        check_bit("scl", scl, 1'b1);
        check_bit("sda_low", sda_low, 1'b0);
        check_bit("pready", pready, 1'b1);
        apb_read(eeprom_pkg::REG_STATUS, data, err);
        check_word("status", data, 32'h0);
        check_bit("pslverr", err, 1'b0);
        apb_write(eeprom_pkg::REG_ADDR, 32'hffff_ffff);
        apb_read(eeprom_pkg::REG_ADDR, data, err);
        check_word("addr", data, 32'h0000_07ff);
        apb_write(eeprom_pkg::REG_WDATA, 32'hffff_ff5a);
        apb_read(eeprom_pkg::REG_WDATA, data, err);
        check_word("wdata", data, 32'h0000_005a);
        apb_read(eeprom_pkg::REG_CMD, data, err);
        check_word("cmd", data, 32'h0);
        apb_read(4'h2, data, err);
        check_bit("pslverr", err, 1'b1);
        apb_read(4'he, data, err);
        check_bit("pslverr", err, 1'b1);
    endtask

    task automatic single_pair();
        write_byte(11'h5a3, 8'hc3);
        check_word("model memory", {24'd0, model_inst.mem[11'h5a3]}, 32'h0000_00c3);
        // same word address in block 0 must be untouched
        check_word("model memory", {24'd0, model_inst.mem[11'h0a3]},
                   {24'd0, exp_mem[11'h0a3]});
        read_byte(11'h5a3);
    endtask

    task automatic random_pairs();
        logic [10:0] addrs [12];
        logic [7:0]  data;
        for (int i = 0; i < 12; i++)
        begin
            rng = xorshift(rng);
            addrs[i] = (i == 6) ? addrs[2] : rng[10:0];  // overwrite an earlier one
            data = rng[23:16];
            write_byte(addrs[i], data);
            read_byte(addrs[i]);
        end
        for (int i = 0; i < 4; i++)
            read_byte(addrs[i]);
    endtask

    task automatic missing_ack();
        logic [10:0]             addr;
        int                      writes_before;
        eeprom_pkg::eeprom_rsp_t exp;
        addr          = 11'h2c7;
        writes_before = write_cnt;
        exp.done      = 1'b1;
        exp.nack      = 1'b1;
        exp.rdata     = last_rdata;
        @(negedge CLK);
        ack_off = 1'b1;
        transfer(addr, ~exp_mem[addr], 2'b01, exp, "nacked write");
        transfer(addr, 8'h00, 2'b10, exp, "nacked read");
        check_word("model memory", {24'd0, model_inst.mem[addr]}, {24'd0, exp_mem[addr]});
        check_word("model write count", write_cnt, writes_before);
        @(negedge CLK);
        ack_off = 1'b0;
    endtask

    task automatic cmd_while_busy();
        logic [10:0] addr;
        logic [31:0] status;
        int          stops_before;
        int          writes_before;
        addr          = 11'h7f0;
        stops_before  = stop_cnt;
        writes_before = write_cnt;
        apb_write(eeprom_pkg::REG_ADDR, {21'd0, addr});
        apb_write(eeprom_pkg::REG_WDATA, 32'h96);
        apb_write(eeprom_pkg::REG_CMD, 32'h1);
        apb_write(eeprom_pkg::REG_WDATA, 32'h69);
        apb_write(eeprom_pkg::REG_CMD, 32'h1);  // dropped
        apb_write(eeprom_pkg::REG_CMD, 32'h2);  // dropped
        wait_done(status);
        check_word("status", status, {16'd0, last_rdata, 8'h02});
        check_word("stop count", stop_cnt - stops_before, 32'd1);
        check_word("model write count", write_cnt - writes_before, 32'd1);
        check_word("model memory", {24'd0, model_inst.mem[addr]}, 32'h0000_0096);
        ends_with_stop("busy write");
        exp_mem[addr] = 8'h96;
        read_byte(addr);
    endtask

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES)
        begin
            @(posedge CLK);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the DUT never finished a transfer", cycle_cnt);
        $display("test failed");
        $finish;
    end

    initial
    begin
        RESET        = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = 4'h0;
        pwdata       = 32'h0;
        ack_off      = 1'b0;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        rng          = 32'hfa6ea5ef;
        last_rdata   = 8'h00;
        repeat (2) @(negedge CLK);
        RESET = 1'b0;
        for (int i = 0; i < 2048; i++)
            exp_mem[i] = model_inst.mem[i];

        reset_and_regs();
        single_pair();
        random_pairs();
        missing_ack();
        cmd_while_busy();

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- eeprom_ctl.f
rtl/eeprom_pkg.sv
rtl/eeprom_apb_regs.sv
rtl/i2c_cond_gen.sv
rtl/i2c_byte_shift.sv
rtl/eeprom_seq.sv
rtl/eeprom_ctl_top.sv
dv/eeprom_model.sv
dv/tb_eeprom_ctl.sv

//--- Makefile
# Verilator build and run for the EEPROM controller testbench

VERILATOR ?= verilator
TOP       ?= tb_eeprom_ctl
FILELIST  ?= eeprom_ctl.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0 --timescale 1ns/1ns -Wno-fatal
PASS_MSG  ?= test passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
